// ==== flist.f ====
+incdir+verification
common/sdio_data_pkg.sv
transfer_sequencer/sdio_transfer_seq.sv
source/sdio_target_router.sv
source/sdio_cmd_byte_port.sv
source/sdio_data_control.sv
verification/tb_sdio_data_control.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SDIO data control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_sdio_data_control \
  -Mdir obj_dir \
  && ./obj_dir/Vtb_sdio_data_control \
  || exit 1

// ==== verification/tb_sdio_tasks.svh ====
// Directed tests, timeout waits and value checks for the SDIO data control testbench

task automatic check_value(input string name, input int got, input int exp);
  assert (got == exp) else begin
    $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
    report_failure();
  end
endtask

task automatic wait_finished(input int max_cycles);
  int n;
  n = 0;
  @(negedge clk);
  while (!finished) begin
    n++;
    assert (n < max_cycles) else begin
      $display("Timed out waiting for o_finished to rise");
      report_failure();
    end
    @(negedge clk);
  end
endtask

task automatic wait_phy_ready();
  int n;
  n = 0;
  @(negedge clk);
  while (!phy_com_rdy) begin
    n++;
    assert (n < 50) else begin
      $display("Timed out waiting for o_data_phy_com_rdy");
      report_failure();
    end
    @(negedge clk);
  end
endtask

task automatic start_transfer(input logic bus, input logic mem, input int func,
                              input logic wr, input logic blk, input int cnt);
  @(posedge clk);
  cmd_bus_sel    <= bus;
  mem_sel        <= mem;
  func_sel       <= 3'(func);
  write_flg      <= wr;
  block_mode_flg <= blk;
  inc_addr_flg   <= 1'b1;
  data_cnt       <= 13'(cnt);
  cmd_address    <= 18'h00100;
  activate       <= 1'b1;
  wr_tgt_log.delete();
  wr_dat_log.delete();
  phy_rd_cnt = 0;
endtask

// Drop activate and wait for the sequencer, o_finished and targets to go quiet
task automatic end_transfer();
  int n;
  n = 0;
  @(posedge clk);
  activate <= 1'b0;
  @(negedge clk);
  while (bus_busy || tgt_activate != '0 || finished) begin
    n++;
    assert (n < 5) else begin
      $display("Transfer did not stop after activate fell");
      report_failure();
    end
    @(negedge clk);
  end
  @(posedge clk);
  cmd_bus_sel <= 1'b0;
endtask

task automatic phy_write_byte(input sdio_data_pkg::byte_t b);
  wait_phy_ready();
  @(posedge clk);
  phy_wr_stb  <= 1'b1;
  phy_wr_data <= b;
  @(posedge clk);
  phy_wr_stb  <= 1'b0;
endtask

task automatic pulse_phy_finished();
  int n;
  n = 0;
  @(negedge clk);
  while (bus_busy) begin
    n++;
    assert (n < 20) else begin
      $display("Sequencer never left the active state");
      report_failure();
    end
    @(negedge clk);
  end
  @(posedge clk);
  phy_finished <= 1'b1;
  @(posedge clk);
  phy_finished <= 1'b0;
endtask

task automatic test_byte_write();
  sdio_data_pkg::byte_t exp [5];
  start_transfer(1'b0, 1'b0, 3, 1'b1, 1'b0, 5);
  for (int i = 0; i < 5; i++) begin
    exp[i] = 8'($random(seed));
    phy_write_byte(exp[i]);
  end
  wait_finished(50);
  check_value("o_total_data_cnt", total_data_cnt, 5);
  check_value("o_address", address, 18'h00105);
  check_value("target write count", wr_tgt_log.size(), 5);
  for (int i = 0; i < 5; i++) begin
    check_value("write target", wr_tgt_log[i], 3);
    check_value("o_tgt_wr_data[3]", wr_dat_log[i], exp[i]);
  end
  end_transfer();
endtask

task automatic test_byte_read_mem();
  exp_rd_tgt = 8;
  start_transfer(1'b0, 1'b1, 0, 1'b0, 1'b0, 0);
  wait_finished(1500);
  check_value("o_total_data_cnt", total_data_cnt, 512);
  check_value("PHY read strobes", phy_rd_cnt, 512);
  end_transfer();
endtask

task automatic test_block_write();
  start_transfer(1'b0, 1'b0, 1, 1'b1, 1'b1, 2);
  for (int b = 0; b < 2; b++) begin
    for (int i = 0; i < 4; i++) begin
      phy_write_byte(8'($random(seed)));
    end
    repeat (3) @(negedge clk);
    check_value("o_total_data_cnt", total_data_cnt, 4);
    check_value("o_finished", finished, 0);
    // Waiting on the PHY keeps the link up with the host not ready
    check_value("o_data_phy_activate", phy_activate, 1);
    check_value("o_tgt_activate", tgt_activate, 9'h002);
    check_value("o_tgt_hst_rdy", tgt_hst_rdy, 0);
    pulse_phy_finished();
  end
  wait_finished(10);
  check_value("target write count", wr_tgt_log.size(), 8);
  end_transfer();
endtask

task automatic test_block_read_cia();
  exp_rd_tgt = 0;
  start_transfer(1'b0, 1'b0, 0, 1'b0, 1'b1, 1);
  wait_finished(600);
  check_value("PHY read strobes", phy_rd_cnt, 4);
  assert (cycle_cnt - last_rd_cycle >= 400) else begin
    $display("Block read finished before the read cooldown had passed");
    report_failure();
  end
  end_transfer();
endtask

task automatic test_cmd_bus_byte();
  sdio_data_pkg::byte_t b;
  b = 8'($random(seed));
  @(posedge clk);
  cmd_wr_data <= b;
  start_transfer(1'b1, 1'b0, 2, 1'b1, 1'b0, 1);
  wait_finished(50);
  check_value("target write count", wr_tgt_log.size(), 1);
  check_value("write target", wr_tgt_log[0], 2);
  check_value("o_tgt_wr_data[2]", wr_dat_log[0], b);
  end_transfer();
  start_transfer(1'b1, 1'b0, 2, 1'b0, 1'b0, 1);
  wait_finished(50);
  check_value("o_cmd_rd_data", cmd_rd_data, pattern[0] ^ 8'd2);
  end_transfer();
endtask

task automatic test_cancel();
  start_transfer(1'b0, 1'b0, 4, 1'b1, 1'b0, 10);
  for (int i = 0; i < 3; i++) begin
    phy_write_byte(8'($random(seed)));
  end
  @(negedge clk);
  check_value("o_finished", finished, 0);
  end_transfer();
  for (int i = 0; i < 5; i++) begin
    @(negedge clk);
    check_value("o_finished", finished, 0);
  end
endtask

// ==== verification/tb_sdio_data_control.sv ====
// Testbench top for the SDIO data control, with clock, reset, DUT and target models
`timescale 1ns/1ps
`default_nettype none

module tb_sdio_data_control;

  logic                       clk;
  logic                       rst;
  logic                       activate;
  logic                       write_flg;
  logic                       block_mode_flg;
  logic                       inc_addr_flg;
  sdio_data_pkg::count_t      data_cnt;
  sdio_data_pkg::address_t    cmd_address;
  logic                       cmd_bus_sel;
  logic                       mem_sel;
  sdio_data_pkg::func_num_t   func_sel;
  sdio_data_pkg::byte_t       cmd_wr_data;
  logic [7:0]                 cmd_rd_data;
  logic                       phy_wr_stb;
  sdio_data_pkg::byte_t       phy_wr_data;
  logic                       phy_rd_stb;
  logic [7:0]                 phy_rd_data;
  logic                       phy_com_rdy;
  logic                       phy_activate;
  logic                       phy_finished;
  logic [8:0]                 tgt_wr_stb;
  sdio_data_pkg::byte_t       tgt_wr_data [sdio_data_pkg::num_targets];
  logic [8:0]                 tgt_hst_rdy;
  logic [8:0]                 tgt_activate;
  logic [8:0]                 tgt_rd_stb;
  sdio_data_pkg::byte_t       tgt_rd_data [sdio_data_pkg::num_targets];
  logic [8:0]                 tgt_com_rdy;
  sdio_data_pkg::block_size_t tgt_block_size [sdio_data_pkg::num_targets];
  logic                       bus_busy;
  logic                       finished;
  sdio_data_pkg::count_t      total_data_cnt;
  sdio_data_pkg::address_t    address;

  // Target model state and monitor bookkeeping
  sdio_data_pkg::byte_t pattern [512];
  logic [8:0]           rd_idx [sdio_data_pkg::num_targets];
  int                   seed;
  int                   cycle_cnt;
  int                   phy_rd_cnt;
  int                   last_rd_cycle;
  int                   exp_rd_tgt;
  int                   wr_tgt_log [$];
  sdio_data_pkg::byte_t wr_dat_log [$];

  sdio_data_control i_sdio_data_control (
    .clk                 (clk),
    .rst                 (rst),
    .i_activate          (activate),
    .i_write_flg         (write_flg),
    .i_block_mode_flg    (block_mode_flg),
    .i_inc_addr_flg      (inc_addr_flg),
    .i_data_cnt          (data_cnt),
    .i_cmd_address       (cmd_address),
    .i_cmd_bus_sel       (cmd_bus_sel),
    .i_mem_sel           (mem_sel),
    .i_func_sel          (func_sel),
    .i_cmd_wr_data       (cmd_wr_data),
    .o_cmd_rd_data       (cmd_rd_data),
    .i_data_phy_wr_stb   (phy_wr_stb),
    .i_data_phy_wr_data  (phy_wr_data),
    .o_data_phy_rd_stb   (phy_rd_stb),
    .o_data_phy_rd_data  (phy_rd_data),
    .o_data_phy_com_rdy  (phy_com_rdy),
    .o_data_phy_activate (phy_activate),
    .i_data_phy_finished (phy_finished),
    .o_tgt_wr_stb        (tgt_wr_stb),
    .o_tgt_wr_data       (tgt_wr_data),
    .o_tgt_hst_rdy       (tgt_hst_rdy),
    .o_tgt_activate      (tgt_activate),
    .i_tgt_rd_stb        (tgt_rd_stb),
    .i_tgt_rd_data       (tgt_rd_data),
    .i_tgt_com_rdy       (tgt_com_rdy),
    .i_tgt_block_size    (tgt_block_size),
    .o_data_bus_busy     (bus_busy),
    .o_finished          (finished),
    .o_total_data_cnt    (total_data_cnt),
    .o_address           (address)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Targets read on every other cycle while the host is ready
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    for (int t = 0; t < sdio_data_pkg::num_targets; t++) begin
      if (rst || !tgt_activate[t]) begin
        rd_idx[t]     <= '0;
        tgt_rd_stb[t] <= 1'b0;
      end else begin
        tgt_rd_stb[t] <= tgt_hst_rdy[t] && !write_flg && !tgt_rd_stb[t];
        if (tgt_rd_stb[t]) begin
          rd_idx[t] <= rd_idx[t] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int t = 0; t < sdio_data_pkg::num_targets; t++) begin
      tgt_rd_data[t]    = pattern[rd_idx[t]] ^ 8'(t);
      tgt_block_size[t] = 16'd4;
    end
  end

  // Monitor samples between clock edges
  always @(negedge clk) begin
    for (int t = 0; t < sdio_data_pkg::num_targets; t++) begin
      if (tgt_wr_stb[t]) begin
        wr_tgt_log.push_back(t);
        wr_dat_log.push_back(tgt_wr_data[t]);
      end
    end
    if (phy_rd_stb) begin
      check_value("o_data_phy_rd_data", phy_rd_data,
                  pattern[phy_rd_cnt[8:0]] ^ 8'(exp_rd_tgt));
      phy_rd_cnt    = phy_rd_cnt + 1;
      last_rd_cycle = cycle_cnt;
    end
    if (cmd_bus_sel) begin
      check_value("PHY outputs", {phy_rd_stb, phy_rd_data, phy_com_rdy, phy_activate}, 0);
    end
  end

  task automatic report_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  `include "tb_sdio_tasks.svh"

  initial begin
    seed           = 9;
    cycle_cnt      = 0;
    phy_rd_cnt     = 0;
    last_rd_cycle  = 0;
    exp_rd_tgt     = 0;
    rst            = 1'b1;
    activate       = 1'b0;
    write_flg      = 1'b0;
    block_mode_flg = 1'b0;
    inc_addr_flg   = 1'b0;
    data_cnt       = '0;
    cmd_address    = '0;
    cmd_bus_sel    = 1'b0;
    mem_sel        = 1'b0;
    func_sel       = '0;
    cmd_wr_data    = '0;
    phy_wr_stb     = 1'b0;
    phy_wr_data    = '0;
    phy_finished   = 1'b0;
    tgt_com_rdy    = '1;
    tgt_rd_stb     = '0;
    for (int t = 0; t < sdio_data_pkg::num_targets; t++) begin
      rd_idx[t] = '0;
    end
    for (int i = 0; i < 512; i++) begin
      pattern[i] = 8'($random(seed));
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("o_finished", finished, 0);
    check_value("o_data_bus_busy", bus_busy, 0);
    check_value("o_data_phy_activate", phy_activate, 0);
    check_value("o_tgt_activate", tgt_activate, 0);
    check_value("o_tgt_hst_rdy", tgt_hst_rdy, 0);
    check_value("o_tgt_wr_stb", tgt_wr_stb, 0);

    test_byte_write();
    test_byte_read_mem();
    test_block_write();
    test_block_read_cia();
    test_cmd_bus_byte();
    test_cancel();

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/sdio_data_control.sv ====
// SDIO data control top, joins host command bus and data PHY to the nine targets
`timescale 1ns/1ps
`default_nettype none

module sdio_data_control (
  input  wire                                clk,
  input  wire                                rst,

  // Command inputs
  input  wire                                i_activate,
  input  wire                                i_write_flg,
  input  wire                                i_block_mode_flg,
  input  wire                                i_inc_addr_flg,
  input  wire sdio_data_pkg::count_t         i_data_cnt,
  input  wire sdio_data_pkg::address_t       i_cmd_address,
  input  wire                                i_cmd_bus_sel,
  input  wire                                i_mem_sel,
  input  wire sdio_data_pkg::func_num_t      i_func_sel,

  // Command bus
  input  wire sdio_data_pkg::byte_t          i_cmd_wr_data,
  output logic [7:0]                         o_cmd_rd_data,

  // Data PHY
  input  wire                                i_data_phy_wr_stb,
  input  wire sdio_data_pkg::byte_t          i_data_phy_wr_data,
  output logic                               o_data_phy_rd_stb,
  output logic [7:0]                         o_data_phy_rd_data,
  output logic                               o_data_phy_com_rdy,
  output logic                               o_data_phy_activate,
  input  wire                                i_data_phy_finished,

  // Targets, indexed by target number
  output logic [sdio_data_pkg::num_targets-1:0] o_tgt_wr_stb,
  output sdio_data_pkg::byte_t               o_tgt_wr_data [sdio_data_pkg::num_targets],
  output logic [sdio_data_pkg::num_targets-1:0] o_tgt_hst_rdy,
  output logic [sdio_data_pkg::num_targets-1:0] o_tgt_activate,
  input  wire  [sdio_data_pkg::num_targets-1:0] i_tgt_rd_stb,
  input  wire sdio_data_pkg::byte_t          i_tgt_rd_data [sdio_data_pkg::num_targets],
  input  wire  [sdio_data_pkg::num_targets-1:0] i_tgt_com_rdy,
  input  wire sdio_data_pkg::block_size_t    i_tgt_block_size [sdio_data_pkg::num_targets],

  // Status
  output logic                               o_data_bus_busy,
  output logic                               o_finished,
  output sdio_data_pkg::count_t              o_total_data_cnt,
  output sdio_data_pkg::address_t            o_address
);

  logic                       data_ready;
  logic                       phy_activate;
  logic                       lcl_wr_stb;
  logic                       bus_wr_stb;
  logic                       bus_rd_stb;
  sdio_data_pkg::byte_t       bus_rd_data;
  logic                       bus_com_rdy;
  sdio_data_pkg::block_size_t sel_block_size;

  sdio_transfer_seq i_sdio_transfer_seq (
    .clk                 (clk),
    .rst                 (rst),
    .i_activate          (i_activate),
    .i_write_flg         (i_write_flg),
    .i_block_mode_flg    (i_block_mode_flg),
    .i_inc_addr_flg      (i_inc_addr_flg),
    .i_data_cnt          (i_data_cnt),
    .i_cmd_address       (i_cmd_address),
    .i_block_size        (sel_block_size),
    .i_wr_stb            (bus_wr_stb),
    .i_rd_stb            (bus_rd_stb),
    .i_data_phy_finished (i_data_phy_finished),
    .o_data_ready        (data_ready),
    .o_phy_activate      (phy_activate),
    .o_busy              (o_data_bus_busy),
    .o_finished          (o_finished),
    .o_total_data_cnt    (o_total_data_cnt),
    .o_address           (o_address)
  );

  sdio_target_router i_sdio_target_router (
    .i_cmd_bus_sel       (i_cmd_bus_sel),
    .i_mem_sel           (i_mem_sel),
    .i_func_sel          (i_func_sel),
    .i_activate          (i_activate),
    .i_phy_activate      (phy_activate),
    .i_data_ready        (data_ready),
    .i_lcl_wr_stb        (lcl_wr_stb),
    .i_cmd_wr_data       (i_cmd_wr_data),
    .i_data_phy_wr_stb   (i_data_phy_wr_stb),
    .i_data_phy_wr_data  (i_data_phy_wr_data),
    .i_tgt_rd_stb        (i_tgt_rd_stb),
    .i_tgt_rd_data       (i_tgt_rd_data),
    .i_tgt_com_rdy       (i_tgt_com_rdy),
    .i_tgt_block_size    (i_tgt_block_size),
    .o_tgt_wr_stb        (o_tgt_wr_stb),
    .o_tgt_wr_data       (o_tgt_wr_data),
    .o_tgt_hst_rdy       (o_tgt_hst_rdy),
    .o_tgt_activate      (o_tgt_activate),
    .o_data_phy_rd_stb   (o_data_phy_rd_stb),
    .o_data_phy_rd_data  (o_data_phy_rd_data),
    .o_data_phy_com_rdy  (o_data_phy_com_rdy),
    .o_data_phy_activate (o_data_phy_activate),
    .o_wr_stb            (bus_wr_stb),
    .o_rd_stb            (bus_rd_stb),
    .o_rd_data           (bus_rd_data),
    .o_com_rdy           (bus_com_rdy),
    .o_block_size        (sel_block_size)
  );

  sdio_cmd_byte_port i_sdio_cmd_byte_port (
    .clk                 (clk),
    .rst                 (rst),
    .i_cmd_bus_sel       (i_cmd_bus_sel),
    .i_activate          (i_activate),
    .i_write_flg         (i_write_flg),
    .i_com_rdy           (bus_com_rdy),
    .i_rd_stb            (bus_rd_stb),
    .i_rd_data           (bus_rd_data),
    .o_lcl_wr_stb        (lcl_wr_stb),
    .o_cmd_rd_data       (o_cmd_rd_data)
  );

endmodule

`default_nettype wire

// ==== source/sdio_cmd_byte_port.sv ====
// Command byte port, moves one byte between the command bus and the selected target
`timescale 1ns/1ps
`default_nettype none

module sdio_cmd_byte_port (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        i_cmd_bus_sel,
  input  wire                        i_activate,
  input  wire                        i_write_flg,
  input  wire                        i_com_rdy,
  input  wire                        i_rd_stb,
  input  wire sdio_data_pkg::byte_t  i_rd_data,
  output logic                       o_lcl_wr_stb,
  output sdio_data_pkg::byte_t       o_cmd_rd_data
);

  sdio_data_pkg::byte_port_state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= sdio_data_pkg::port_idle;
      o_lcl_wr_stb <= 1'b0;
    end else begin
      o_lcl_wr_stb <= 1'b0;
      case (state)
        sdio_data_pkg::port_idle: begin
          if (i_cmd_bus_sel && i_activate) begin
            state <= i_write_flg ? sdio_data_pkg::port_write : sdio_data_pkg::port_read;
          end
        end
        sdio_data_pkg::port_write: begin
          // Target may hold off indefinitely
          if (i_com_rdy) begin
            o_lcl_wr_stb <= 1'b1;
            state        <= sdio_data_pkg::port_done;
          end
        end
        sdio_data_pkg::port_read: begin
          if (i_rd_stb) begin
            state <= sdio_data_pkg::port_done;
          end
        end
        default: begin
          if (!i_activate) begin
            state <= sdio_data_pkg::port_idle;
          end
        end
      endcase

      // Cancel from any state
      if (!i_activate) begin
        state <= sdio_data_pkg::port_idle;
      end
    end
  end

  // Read byte stays on the bus until the next read
  always_ff @(posedge clk) begin
    if (state == sdio_data_pkg::port_read && i_rd_stb) begin
      o_cmd_rd_data <= i_rd_data;
    end
  end

  a_single_wr_pulse: assert property (@(posedge clk) disable iff (rst)
    o_lcl_wr_stb |=> !o_lcl_wr_stb);

endmodule

`default_nettype wire

// ==== source/sdio_target_router.sv ====
// Target router, steers writes and activate to one target and gathers its read side
`timescale 1ns/1ps
`default_nettype none

module sdio_target_router (
  input  wire                                i_cmd_bus_sel,
  input  wire                                i_mem_sel,
  input  wire sdio_data_pkg::func_num_t      i_func_sel,
  input  wire                                i_activate,
  input  wire                                i_phy_activate,
  input  wire                                i_data_ready,
  input  wire                                i_lcl_wr_stb,
  input  wire sdio_data_pkg::byte_t          i_cmd_wr_data,
  input  wire                                i_data_phy_wr_stb,
  input  wire sdio_data_pkg::byte_t          i_data_phy_wr_data,
  input  wire  [sdio_data_pkg::num_targets-1:0] i_tgt_rd_stb,
  input  wire sdio_data_pkg::byte_t          i_tgt_rd_data [sdio_data_pkg::num_targets],
  input  wire  [sdio_data_pkg::num_targets-1:0] i_tgt_com_rdy,
  input  wire sdio_data_pkg::block_size_t    i_tgt_block_size [sdio_data_pkg::num_targets],
  output logic [sdio_data_pkg::num_targets-1:0] o_tgt_wr_stb,
  output sdio_data_pkg::byte_t               o_tgt_wr_data [sdio_data_pkg::num_targets],
  output logic [sdio_data_pkg::num_targets-1:0] o_tgt_hst_rdy,
  output logic [sdio_data_pkg::num_targets-1:0] o_tgt_activate,
  output logic                               o_data_phy_rd_stb,
  output logic [7:0]                         o_data_phy_rd_data,
  output logic                               o_data_phy_com_rdy,
  output logic                               o_data_phy_activate,
  output logic                               o_wr_stb,
  output logic                               o_rd_stb,
  output sdio_data_pkg::byte_t               o_rd_data,
  output logic                               o_com_rdy,
  output sdio_data_pkg::block_size_t         o_block_size
);

  sdio_data_pkg::target_idx_t sel;
  sdio_data_pkg::byte_t       wr_data;
  logic                       activate;

  // Memory select wins over the function number
  assign sel = i_mem_sel ? sdio_data_pkg::mem_target : {1'b0, i_func_sel};

  // Write source
  assign o_wr_stb = i_cmd_bus_sel ? i_lcl_wr_stb  : i_data_phy_wr_stb;
  assign wr_data  = i_cmd_bus_sel ? i_cmd_wr_data : i_data_phy_wr_data;
  assign activate = i_cmd_bus_sel ? i_activate    : i_phy_activate;

  always_comb begin
    o_tgt_wr_stb   = '0;
    o_tgt_hst_rdy  = '0;
    o_tgt_activate = '0;
    for (int t = 0; t < sdio_data_pkg::num_targets; t++) begin
      o_tgt_wr_data[t] = '0;
    end
    o_tgt_wr_stb[sel]   = o_wr_stb;
    o_tgt_wr_data[sel]  = wr_data;
    o_tgt_hst_rdy[sel]  = i_data_ready;
    o_tgt_activate[sel] = activate;
  end

  // Read side of the selected target
  assign o_rd_stb     = i_tgt_rd_stb[sel];
  assign o_rd_data    = i_tgt_rd_data[sel];
  assign o_com_rdy    = i_tgt_com_rdy[sel] & i_data_ready;
  assign o_block_size = i_tgt_block_size[sel];

  // PHY is silent while the command bus owns the targets
  assign o_data_phy_rd_stb   = !i_cmd_bus_sel && o_rd_stb;
  assign o_data_phy_rd_data  = i_cmd_bus_sel ? 8'h00 : o_rd_data;
  assign o_data_phy_com_rdy  = !i_cmd_bus_sel && o_com_rdy;
  assign o_data_phy_activate = !i_cmd_bus_sel && i_phy_activate;

  always_comb begin
    a_single_wr_target: assert final ($onehot0(o_tgt_wr_stb));
  end

endmodule

`default_nettype wire

// ==== transfer_sequencer/sdio_transfer_seq.sv ====
// Transfer sequencer, sizes byte and block transfers, counts strobes and paces blocks
`timescale 1ns/1ps
`default_nettype none

module sdio_transfer_seq (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             i_activate,
  input  wire                             i_write_flg,
  input  wire                             i_block_mode_flg,
  input  wire                             i_inc_addr_flg,
  input  wire sdio_data_pkg::count_t      i_data_cnt,
  input  wire sdio_data_pkg::address_t    i_cmd_address,
  input  wire sdio_data_pkg::block_size_t i_block_size,
  input  wire                             i_wr_stb,
  input  wire                             i_rd_stb,
  input  wire                             i_data_phy_finished,
  output logic                            o_data_ready,
  output logic                            o_phy_activate,
  output logic                            o_busy,
  output logic                            o_finished,
  output sdio_data_pkg::count_t           o_total_data_cnt,
  output sdio_data_pkg::address_t         o_address
);

  sdio_data_pkg::seq_state_t state;
  sdio_data_pkg::count_t     total_blocks;
  sdio_data_pkg::count_t     block_cnt;
  sdio_data_pkg::count_t     byte_cnt;
  sdio_data_pkg::count_t     cooldown_cnt;
  logic                      continuous;
  logic                      block_open;
  logic                      more_blocks;

  // Bytes still owed in the current block
  assign block_open  = (byte_cnt < o_total_data_cnt);
  // Zero block count in block mode runs until activate drops
  assign more_blocks = continuous || (block_cnt < total_blocks);

  assign o_busy         = (state == sdio_data_pkg::seq_active);
  assign o_data_ready   = (state == sdio_data_pkg::seq_active) && block_open;
  assign o_phy_activate = (state == sdio_data_pkg::seq_active) ||
                          (state == sdio_data_pkg::seq_wait_phy) ||
                          (state == sdio_data_pkg::seq_cooldown);

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= sdio_data_pkg::seq_idle;
      total_blocks     <= '0;
      block_cnt        <= '0;
      byte_cnt         <= '0;
      cooldown_cnt     <= '0;
      continuous       <= 1'b0;
      o_total_data_cnt <= '0;
      o_address        <= '0;
    end else begin
      case (state)
        sdio_data_pkg::seq_idle: begin
          byte_cnt         <= '0;
          block_cnt        <= '0;
          o_total_data_cnt <= '0;
          o_address        <= i_cmd_address;
          total_blocks     <= i_block_mode_flg ? i_data_cnt : '0;
          continuous       <= i_block_mode_flg && (i_data_cnt == '0);
          if (i_activate) begin
            state <= sdio_data_pkg::seq_config;
          end
        end
        sdio_data_pkg::seq_config: begin
          byte_cnt <= '0;
          if (i_block_mode_flg) begin
            o_total_data_cnt <= sdio_data_pkg::count_t'(i_block_size);
            if (!continuous) begin
              block_cnt <= block_cnt + 1'b1;
            end
          end else if (i_data_cnt == '0) begin
            o_total_data_cnt <= sdio_data_pkg::default_byte_count;
          end else begin
            o_total_data_cnt <= i_data_cnt;
          end
          state <= sdio_data_pkg::seq_active;
        end
        sdio_data_pkg::seq_active: begin
          if (block_open) begin
            if (i_wr_stb || i_rd_stb) begin
              byte_cnt <= byte_cnt + 1'b1;
              if (i_inc_addr_flg) begin
                o_address <= o_address + 1'b1;
              end
            end
          end else if (!i_block_mode_flg) begin
            state <= sdio_data_pkg::seq_done;
          end else if (i_write_flg) begin
            state <= sdio_data_pkg::seq_wait_phy;
          end else begin
            cooldown_cnt <= '0;
            state        <= sdio_data_pkg::seq_cooldown;
          end
        end
        sdio_data_pkg::seq_wait_phy: begin
          // PHY reports the write block has gone out
          if (i_data_phy_finished) begin
            state <= more_blocks ? sdio_data_pkg::seq_config : sdio_data_pkg::seq_done;
          end
        end
        sdio_data_pkg::seq_cooldown: begin
          if (cooldown_cnt < sdio_data_pkg::read_cooldown_cycles - 1'b1) begin
            cooldown_cnt <= cooldown_cnt + 1'b1;
          end else begin
            state <= more_blocks ? sdio_data_pkg::seq_config : sdio_data_pkg::seq_done;
          end
        end
        sdio_data_pkg::seq_done: begin
          state <= sdio_data_pkg::seq_done;
        end
        default: begin
          state <= sdio_data_pkg::seq_idle;
        end
      endcase

      // Dropping activate cancels or closes any transfer
      if (!i_activate) begin
        state <= sdio_data_pkg::seq_idle;
      end
    end
  end

  // Held until activate falls
  always_ff @(posedge clk) begin
    if (rst) begin
      o_finished <= 1'b0;
    end else begin
      o_finished <= (state == sdio_data_pkg::seq_done) && i_activate;
    end
  end

  a_count_in_range: assert property (@(posedge clk) disable iff (rst)
    byte_cnt <= o_total_data_cnt);

  a_finished_needs_activate: assert property (@(posedge clk) disable iff (rst)
    o_finished |-> $past(i_activate));

endmodule

`default_nettype wire

// ==== common/sdio_data_pkg.sv ====
// SDIO data-path package with target numbering, widths, states and timing constants
`default_nettype none

package sdio_data_pkg;

  // CIA is 0, functions 1 to 7, memory last
  localparam int num_targets = 9;

  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  target_idx_t;
  typedef logic [2:0]  func_num_t;
  typedef logic [12:0] count_t;
  typedef logic [15:0] block_size_t;
  typedef logic [17:0] address_t;

  localparam target_idx_t mem_target = 4'd8;

  // Byte mode count of zero
  localparam count_t default_byte_count = 13'd512;

  // Idle gap after every read block
  localparam count_t read_cooldown_cycles = 13'd400;

  typedef enum logic [2:0] {
    seq_idle,
    seq_config,
    seq_active,
    seq_wait_phy,
    seq_cooldown,
    seq_done
  } seq_state_t;

  typedef enum logic [1:0] {
    port_idle,
    port_write,
    port_read,
    port_done
  } byte_port_state_t;

endpackage

`default_nettype wire
